/* design/aurora_tx_pkg.sv */
// ============================================================
// shared types and link constants for the clk160 transmit path
// header sits in the low two bits of a block, sent first
// ============================================================
`default_nettype none

package aurora_tx_pkg;

    // ============================================================
    // widths that carry a meaning
    // ============================================================
    typedef logic [63:0] payload_t;
    typedef logic [1:0]  sync_hdr_t;
    typedef logic [31:0] word_t;
    typedef logic [7:0]  byte_t;

    // payload in the high bits, header in bits 1:0
    typedef struct packed {
        payload_t  payload;
        sync_hdr_t hdr;
    } tx_block_t;

    // payload source selection, driven from outside
    typedef enum logic [1:0] {
        mode_ber   = 2'd0,
        mode_count = 2'd1,
        mode_user  = 2'd2
    } tx_mode_t;

    // req side of the source/gearbox handshake
    typedef enum logic [1:0] {
        idle         = 2'd0,
        req_high     = 2'd1,
        wait_ack_low = 2'd2
    } src_state_t;

    // ============================================================
    // link constants
    // ============================================================
    // fixed bit error rate pattern, sent with control header
    localparam payload_t  BER_PATTERN = 64'hB0B5_C0CA_C01A_CAFE;
    localparam sync_hdr_t HDR_DATA    = 2'b01;
    localparam sync_hdr_t HDR_CTRL    = 2'b10;

    // scrambler 1 + x^39 + x^58, taps as state indices
    localparam int SCR_TAP_A      = 38;
    localparam int SCR_TAP_B      = 57;
    localparam int SCR_STATE_BITS = 58;

    // gearbox sizing, two blocks of room
    localparam int GB_BUF_BITS     = 132;
    localparam int GB_REFILL_BELOW = 66;
    localparam int GB_START_FILL   = 64;

    localparam int BYTES_PER_WORD = 4;

endpackage : aurora_tx_pkg

`default_nettype wire

/* design/block_source.sv */
// ============================================================
// one 66-bit block per four-phase handshake, payload scrambled
// mode and user_data are only sampled while forming a block
// ============================================================
`timescale 1ns/1ps
`default_nettype none

module block_source (
    input  logic                    clk160,
    input  logic                    rst,
    input  aurora_tx_pkg::tx_mode_t mode,
    input  aurora_tx_pkg::payload_t user_data,
    input  logic                    blk_ack,
    output aurora_tx_pkg::tx_block_t blk,
    output logic                    blk_req
);

    import aurora_tx_pkg::*;

    src_state_t                state;
    payload_t                  count_q;
    logic [SCR_STATE_BITS-1:0] scr_state;

    // next block before scrambling
    payload_t  pay_sel;
    sync_hdr_t hdr_sel;

    // scrambled payload and the state after 64 bits
    payload_t                  pay_scr;
    logic [SCR_STATE_BITS-1:0] scr_next;

    // ============================================================
    // payload selection
    // ============================================================
    always_comb begin
        case (mode)
            mode_count: begin
                pay_sel = count_q;
                hdr_sel = HDR_DATA;
            end
            mode_user: begin
                pay_sel = user_data;
                hdr_sel = HDR_DATA;
            end
            // ber and the unused code
            default: begin
                pay_sel = BER_PATTERN;
                hdr_sel = HDR_CTRL;
            end
        endcase
    end

    // ============================================================
    // self-synchronous scrambler, bit 0 first
    // ============================================================
    always_comb begin
        logic sb;
        scr_next = scr_state;
        for (int i = 0; i < $bits(payload_t); i++) begin
            sb = pay_sel[i] ^ scr_next[SCR_TAP_A] ^ scr_next[SCR_TAP_B];
            pay_scr[i] = sb;
            // newest scrambled bit enters at index 0
            scr_next = {scr_next[SCR_STATE_BITS-2:0], sb};
        end
    end

    // ============================================================
    // handshake FSM
    // ============================================================
    always_ff @(posedge clk160) begin
        if (rst) begin
            state     <= idle;
            blk_req   <= 1'b0;
            count_q   <= '0;
            scr_state <= '0;
        end else begin
            case (state)
                // form a block, commit scrambler and counter
                idle: begin
                    blk_req   <= 1'b1;
                    scr_state <= scr_next;
                    if (mode == mode_count) begin
                        count_q <= count_q + 64'd1;
                    end
                    state <= req_high;
                end
                // hold req and blk until the gearbox takes it
                req_high: begin
                    if (blk_ack) begin
                        blk_req <= 1'b0;
                        state   <= wait_ack_low;
                    end
                end
                // ack must drop before the next block
                wait_ack_low: begin
                    if (!blk_ack) begin
                        state <= idle;
                    end
                end
                default: begin
                    blk_req <= 1'b0;
                    state   <= idle;
                end
            endcase
        end
    end

    // block register, only written while forming
    always_ff @(posedge clk160) begin
        if (state == idle) begin
            blk.payload <= pay_scr;
            blk.hdr     <= hdr_sel;
        end
    end

endmodule : block_source

`default_nettype wire

/* design/tx_gearbox.sv */
// ============================================================
// 66-bit blocks in, 32-bit words out, oldest bits in word[31:0]
// the consumer must not take before word_ready, nor take faster
// than 32 bits per 4 cycles
// ============================================================
`timescale 1ns/1ps
`default_nettype none

module tx_gearbox (
    input  logic                     clk160,
    input  logic                     rst,
    input  aurora_tx_pkg::tx_block_t blk,
    input  logic                     blk_req,
    input  logic                     word_take,
    output logic                     blk_ack,
    output aurora_tx_pkg::word_t     word,
    output logic                     word_ready
);

    import aurora_tx_pkg::*;

    // bit store, valid bits are [fill-1:0]
    logic [GB_BUF_BITS-1:0] gb_buf;
    // fill level in bits, 0 to 131
    logic [7:0]             fill;

    logic                   accept;
    logic [7:0]             fill_base;
    logic [7:0]             fill_next;
    logic [GB_BUF_BITS-1:0] buf_shift;
    logic [GB_BUF_BITS-1:0] ins_mask;
    logic [GB_BUF_BITS-1:0] ins_data;
    logic [GB_BUF_BITS-1:0] buf_next;

    // ============================================================
    // block acceptance
    // ============================================================
    // new req only, and room for a whole block
    assign accept = blk_req && !blk_ack && (fill < GB_REFILL_BELOW);

    // ============================================================
    // buffer update
    // ============================================================
    always_comb begin
        // take first, drop the oldest word
        if (word_take) begin
            buf_shift = gb_buf >> $bits(word_t);
            fill_base = fill - 8'($bits(word_t));
        end else begin
            buf_shift = gb_buf;
            fill_base = fill;
        end

        // block lands right above what is left
        ins_mask = GB_BUF_BITS'({$bits(tx_block_t){1'b1}}) << fill_base;
        ins_data = GB_BUF_BITS'(blk) << fill_base;

        if (accept) begin
            buf_next  = (buf_shift & ~ins_mask) | ins_data;
            fill_next = fill_base + 8'($bits(tx_block_t));
        end else begin
            buf_next  = buf_shift;
            fill_next = fill_base;
        end
    end

    always_ff @(posedge clk160) begin
        gb_buf <= buf_next;
    end

    always_ff @(posedge clk160) begin
        if (rst) begin
            fill <= '0;
        end else begin
            fill <= fill_next;
        end
    end

    // ============================================================
    // ack phases
    // ============================================================
    always_ff @(posedge clk160) begin
        if (rst) begin
            blk_ack <= 1'b0;
        end else if (accept) begin
            // same edge the block is written
            blk_ack <= 1'b1;
        end else if (blk_ack && !blk_req) begin
            blk_ack <= 1'b0;
        end
    end

    // ============================================================
    // word side
    // ============================================================
    // sticky, buffer sizing keeps it fed from here on
    always_ff @(posedge clk160) begin
        if (rst) begin
            word_ready <= 1'b0;
        end else if (fill >= GB_START_FILL) begin
            word_ready <= 1'b1;
        end
    end

    // oldest bits, header leads
    assign word = gb_buf[$bits(word_t)-1:0];

endmodule : tx_gearbox

`default_nettype wire

/* design/byte_serializer.sv */
// ============================================================
// 32-bit word out as 4 bytes, low byte first, one per cycle
// never stalls once started, relies on the gearbox staying fed
// ============================================================
`timescale 1ns/1ps
`default_nettype none

module byte_serializer (
    input  logic                 clk160,
    input  logic                 rst,
    input  aurora_tx_pkg::word_t word,
    input  logic                 word_ready,
    output logic                 word_take,
    output aurora_tx_pkg::byte_t tx_byte,
    output logic                 byte_valid
);

    import aurora_tx_pkg::*;

    logic       running;
    logic [1:0] byte_cnt;
    word_t      shreg;

    // load slot, once per word
    assign word_take = running && (byte_cnt == 2'd0);

    // ============================================================
    // pacing
    // ============================================================
    always_ff @(posedge clk160) begin
        if (rst) begin
            running  <= 1'b0;
            byte_cnt <= '0;
        end else begin
            if (word_ready) begin
                running <= 1'b1;
            end
            if (running) begin
                if (byte_cnt == 2'(BYTES_PER_WORD - 1)) begin
                    byte_cnt <= '0;
                end else begin
                    byte_cnt <= byte_cnt + 2'd1;
                end
            end
        end
    end

    // ============================================================
    // shifter
    // ============================================================
    always_ff @(posedge clk160) begin
        if (rst) begin
            shreg      <= '0;
            byte_valid <= 1'b0;
        end else if (word_take) begin
            shreg      <= word;
            // first load starts the byte stream
            byte_valid <= 1'b1;
        end else begin
            shreg <= {8'h00, shreg[$bits(word_t)-1:8]};
        end
    end

    assign tx_byte = shreg[7:0];

endmodule : byte_serializer

`default_nettype wire

/* design/aurora_tx_top.sv */
// ============================================================
// transmit path, single clk160 domain, sync reset
// ============================================================
`timescale 1ns/1ps
`default_nettype none

module aurora_tx_top (
    input  logic                    clk160,
    input  logic                    rst,
    input  aurora_tx_pkg::tx_mode_t mode,
    input  aurora_tx_pkg::payload_t user_data,
    output aurora_tx_pkg::byte_t    tx_byte,
    output logic                    byte_valid
);

    import aurora_tx_pkg::*;

    // source to gearbox, four-phase
    tx_block_t blk;
    logic      blk_req;
    logic      blk_ack;

    // gearbox to serializer
    word_t     word;
    logic      word_ready;
    logic      word_take;

    block_source u_source (
        .clk160    (clk160),
        .rst       (rst),
        .mode      (mode),
        .user_data (user_data),
        .blk_ack   (blk_ack),
        .blk       (blk),
        .blk_req   (blk_req)
    );

    tx_gearbox u_gearbox (
        .clk160     (clk160),
        .rst        (rst),
        .blk        (blk),
        .blk_req    (blk_req),
        .word_take  (word_take),
        .blk_ack    (blk_ack),
        .word       (word),
        .word_ready (word_ready)
    );

    byte_serializer u_serializer (
        .clk160     (clk160),
        .rst        (rst),
        .word       (word),
        .word_ready (word_ready),
        .word_take  (word_take),
        .tx_byte    (tx_byte),
        .byte_valid (byte_valid)
    );

endmodule : aurora_tx_top

`default_nettype wire

/* verif/tb_aurora_tx_tasks.svh */
// ============================================================
// helpers and directed tests included inside tb_aurora_tx
// queue checks run on rising edges and the collector on falling
// ============================================================
`ifndef TB_AURORA_TX_TASKS_SVH
`define TB_AURORA_TX_TASKS_SVH

    // next user word half with numerical recipes constants
    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    task automatic report_mismatch(input string name, input logic [63:0] exp,
                                   input logic [63:0] act);
        $display("[FAIL] %0t %s expected 0x%0h got 0x%0h", $time, name, exp, act);
        error_count++;
    endtask

    // quiet outputs sampled mid cycle
    task automatic check_idle_outputs();
        if (byte_valid !== 1'b0) begin
            report_mismatch("byte_valid", 64'd0, 64'(byte_valid));
        end
        if (tx_byte !== 8'h00) begin
            report_mismatch("tx_byte", 64'd0, 64'(tx_byte));
        end
    endtask

    // rst high for 8 sampled edges
    task automatic apply_reset(input bit check_outputs);
        @(posedge clk160);
        rst <= 1'b1;
        for (int i = 0; i < 8; i++) begin
            @(negedge clk160);
            // DUT sees rst from the edge after it is driven
            if (check_outputs && i > 0) begin
                check_idle_outputs();
            end
            @(posedge clk160);
        end
        rst <= 1'b0;
    endtask

    // bounded wait for n recovered blocks
    task automatic wait_blocks(input int n, input int limit, output bit ok);
        int cycles;
        cycles = 0;
        while (rx_q.size() < n && cycles < limit) begin
            @(posedge clk160);
            cycles++;
        end
        ok = (rx_q.size() >= n);
        if (!ok) begin
            $display("timeout: only %0d of %0d blocks arrived", rx_q.size(), n);
            timeout_count++;
        end
    endtask

    // ============================================================
    // directed tests
    // ============================================================
    task automatic reset_quiet();
        @(posedge clk160);
        mode <= mode_ber;
        apply_reset(1'b1);
        // first cycle out of reset
        @(negedge clk160);
        check_idle_outputs();
    endtask

    task automatic ber_pattern_blocks();
        bit ok;
        @(posedge clk160);
        mode <= mode_ber;
        apply_reset(1'b0);
        wait_blocks(20, 3000, ok);
        for (int i = 0; ok && i < 20; i++) begin
            if (rx_q[i].hdr !== 2'b10) begin
                report_mismatch("ber header", 64'h2, 64'(rx_q[i].hdr));
            end
            if (rx_q[i].payload !== 64'hB0B5_C0CA_C01A_CAFE) begin
                report_mismatch("ber payload", 64'hB0B5_C0CA_C01A_CAFE, rx_q[i].payload);
            end
        end
    endtask

    task automatic counting_blocks();
        bit          ok;
        logic [63:0] expect_val;
        @(posedge clk160);
        mode <= mode_count;
        apply_reset(1'b0);
        wait_blocks(20, 3000, ok);
        expect_val = 64'd0;
        for (int i = 0; ok && i < 20; i++) begin
            if (rx_q[i].hdr !== 2'b01) begin
                report_mismatch("count header", 64'h1, 64'(rx_q[i].hdr));
            end
            if (rx_q[i].payload !== expect_val) begin
                report_mismatch("count payload", expect_val, rx_q[i].payload);
            end
            // counter starts at zero and steps by one per block
            expect_val = expect_val + 64'd1;
        end
    endtask

    task automatic user_word_blocks(input logic [63:0] value);
        bit ok;
        @(posedge clk160);
        user_data <= value;
        mode <= mode_user;
        apply_reset(1'b0);
        wait_blocks(20, 3000, ok);
        for (int i = 0; ok && i < 20; i++) begin
            if (rx_q[i].hdr !== 2'b01) begin
                report_mismatch("user header", 64'h1, 64'(rx_q[i].hdr));
            end
            if (rx_q[i].payload !== value) begin
                report_mismatch("user payload", value, rx_q[i].payload);
            end
        end
    endtask

    // no underrun gap once the byte stream has started
    task automatic stream_continuity(input tx_mode_t m);
        int          cycles;
        int          gaps;
        logic [1:0]  exp_hdr;
        logic [63:0] exp_pay;
        @(posedge clk160);
        mode <= m;
        apply_reset(1'b0);
        cycles = 0;
        gaps = 0;
        while (byte_valid !== 1'b1 && cycles < 1000) begin
            @(negedge clk160);
            cycles++;
        end
        if (byte_valid !== 1'b1) begin
            $display("timeout: byte_valid never rose in mode %s", m.name());
            timeout_count++;
        end else begin
            for (int i = 0; i < 2000; i++) begin
                @(negedge clk160);
                if (byte_valid !== 1'b1) begin
                    gaps++;
                end
            end
            if (gaps != 0) begin
                $display("byte_valid dropped in %0d cycles in mode %s", gaps, m.name());
                error_count++;
            end
            // an underrun would show up as corrupted blocks in the window
            @(posedge clk160);
            for (int i = 0; i < rx_q.size(); i++) begin
                case (m)
                    mode_count: begin
                        exp_hdr = 2'b01;
                        exp_pay = 64'(i);
                    end
                    mode_user: begin
                        exp_hdr = 2'b01;
                        exp_pay = user_data;
                    end
                    default: begin
                        exp_hdr = 2'b10;
                        exp_pay = 64'hB0B5_C0CA_C01A_CAFE;
                    end
                endcase
                if (rx_q[i].hdr !== exp_hdr) begin
                    report_mismatch("stream header", 64'(exp_hdr), 64'(rx_q[i].hdr));
                end
                if (rx_q[i].payload !== exp_pay) begin
                    report_mismatch("stream payload", exp_pay, rx_q[i].payload);
                end
            end
        end
    endtask

`endif

/* verif/tb_aurora_tx.sv */
// ============================================================
// directed testbench recovering blocks from the byte stream
// the reference descrambler resets together with the DUT
// ============================================================
`timescale 1ns/1ps
`default_nettype none

module tb_aurora_tx;

    import aurora_tx_pkg::*;

    logic     clk160;
    logic     rst;
    tx_mode_t mode;
    payload_t user_data;
    byte_t    tx_byte;
    logic     byte_valid;

    // recovered blocks since the last reset in arrival order
    tx_block_t rx_q[$];

    // collector bits land at the top and walk down
    logic [65:0] acc;
    int          acc_n;
    logic [57:0] dscr;

    int          error_count;
    int          timeout_count;
    logic [31:0] lcg_state;
    payload_t    user_a;
    payload_t    user_b;

    aurora_tx_top u_dut (
        .clk160     (clk160),
        .rst        (rst),
        .mode       (mode),
        .user_data  (user_data),
        .tx_byte    (tx_byte),
        .byte_valid (byte_valid)
    );

    // 20 ns period
    initial begin
        clk160 = 1'b0;
        forever #10 clk160 = ~clk160;
    end

    `include "tb_aurora_tx_tasks.svh"

    // ============================================================
    // reference descrambler with the header passed through
    // ============================================================
    task automatic descramble_block(input logic [65:0] rx);
        logic [65:0] sh;
        logic [63:0] pay;
        logic        in_bit;
        tx_block_t   blk_rx;
        sh = rx >> 2;
        pay = '0;
        for (int i = 0; i < 64; i++) begin
            in_bit = sh[0];
            sh = sh >> 1;
            // out = in ^ s[38] ^ s[57] with the received bit shifted in
            pay = {in_bit ^ dscr[38] ^ dscr[57], pay[63:1]};
            dscr = {dscr[56:0], in_bit};
        end
        blk_rx.hdr = rx[1:0];
        blk_rx.payload = pay;
        rx_q.push_back(blk_rx);
    endtask

    // ============================================================
    // byte collector packing LSB first into 66-bit blocks
    // ============================================================
    always @(negedge clk160) begin
        logic [7:0] bb;
        if (rst) begin
            acc_n = 0;
            acc = '0;
            dscr = '0;
            rx_q.delete();
        end else if (byte_valid) begin
            bb = tx_byte;
            for (int b = 0; b < 8; b++) begin
                acc = {bb[0], acc[65:1]};
                bb = bb >> 1;
                acc_n++;
                // first received bit is now at index 0
                if (acc_n == 66) begin
                    descramble_block(acc);
                    acc_n = 0;
                end
            end
        end
    end

    // ============================================================
    // test sequence
    // ============================================================
    initial begin
        rst = 1'b1;
        mode = mode_ber;
        user_data = '0;
        error_count = 0;
        timeout_count = 0;
        lcg_state = 32'hfba33bba;

        reset_quiet();
        ber_pattern_blocks();
        counting_blocks();
        user_a[63:32] = lcg_next();
        user_a[31:0] = lcg_next();
        user_word_blocks(user_a);
        user_b[63:32] = lcg_next();
        user_b[31:0] = lcg_next();
        user_word_blocks(user_b);
        stream_continuity(mode_ber);
        stream_continuity(mode_count);
        stream_continuity(mode_user);

        $display("summary: %0d errors, %0d timeouts", error_count, timeout_count);
        if (error_count == 0 && timeout_count == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule : tb_aurora_tx

`default_nettype wire

/* filelist.f */
+incdir+verif
design/aurora_tx_pkg.sv
design/block_source.sv
design/tx_gearbox.sv
design/byte_serializer.sv
design/aurora_tx_top.sv
verif/tb_aurora_tx.sv

/* run_sim.sh */
#!/bin/sh
# Verilator build and run of the transmit path testbench
set -e

cd "$(dirname "$0")"

LOG=sim.log

rm -rf obj_dir

verilator --binary --timing \
    --top-module tb_aurora_tx \
    -f filelist.f \
    -o Vtb_aurora_tx

./obj_dir/Vtb_aurora_tx > "$LOG" 2>&1

cat "$LOG"

if grep -q "\*\*\* FAILED \*\*\*" "$LOG"; then
    echo "simulation reported failure"
    exit 1
fi

echo "simulation finished without failure"
exit 0
